// ==== include/rv_config.svh ====
/*
 * RV32I subset core configuration
 * Word width, unified memory geometry, reset PC and the start of
 * the data region used by loads and stores
 */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width, one word
`define RV_XLEN 32

// Unified memory, in words
`define RV_MEM_WORDS 1024
// Word address bits into the memory
`define RV_MEM_AW 10

// First fetch address after reset or run start
`define RV_RESET_PC 32'h0000_0000
// Byte address where the data region begins
`define RV_DATA_BASE 1024

`endif

// ==== rtl/core_top.sv ====
/*
 * core_top
 * Five-stage RV32I subset core. Fetch and data share one memory
 * with a program load port; each writeback is one retirement
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module core_top import rv_pkg::*; (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_run,
  input  wire                 i_load_we,
  input  wire [`RV_XLEN-1:0]  i_load_addr,
  input  wire [`RV_XLEN-1:0]  i_load_data,
  output logic                o_wb_valid,
  output logic [4:0]          o_wb_rd,
  output logic [`RV_XLEN-1:0] o_wb_data
);

  logic [`RV_XLEN-1:0] if_pc;
  instr_t              if_instr;
  logic                if_valid;
  logic                stall;
  logic                redirect;
  logic [`RV_XLEN-1:0] target;
  id_ex_t              id_ex;
  ex_mem_t             ex_mem;
  logic [`RV_XLEN-1:0] fwd_result;
  logic [4:0]          fwd_rd;
  logic                fwd_we;
  logic                wb_we;

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();

  // Retirement strobe
  assign o_wb_valid = wb_we;

  shared_memory u_mem (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_load_we   (i_load_we),
    .i_load_addr (i_load_addr),
    .i_load_data (i_load_data),
    .i_run       (i_run),
    .fetch       (fetch_bus.memory),
    .data        (data_bus.memory)
  );

  fetch_stage u_fetch (
    .i_clk (i_clk), .i_reset (i_reset), .i_run (i_run),
    .i_stall (stall), .i_redirect (redirect), .i_target (target),
    .bus (fetch_bus.requester),
    .o_if_pc (if_pc), .o_if_instr (if_instr), .o_if_valid (if_valid)
  );

  decode_stage u_decode (
    .i_clk (i_clk), .i_reset (i_reset), .i_run (i_run),
    .i_if_pc (if_pc), .i_if_instr (if_instr), .i_if_valid (if_valid),
    .i_redirect (redirect),
    .i_wb_we (wb_we), .i_wb_rd (o_wb_rd), .i_wb_data (o_wb_data),
    .o_stall (stall), .o_id_ex (id_ex)
  );

  execute_stage u_execute (
    .i_clk (i_clk), .i_reset (i_reset), .i_run (i_run), .i_id_ex (id_ex),
    .i_mem_fwd_result (fwd_result), .i_mem_fwd_rd (fwd_rd), .i_mem_fwd_we (fwd_we),
    .i_wb_data (o_wb_data), .i_wb_rd (o_wb_rd), .i_wb_we (wb_we),
    .o_redirect (redirect), .o_target (target), .o_ex_mem (ex_mem)
  );

  memory_stage u_memory (
    .i_clk (i_clk), .i_reset (i_reset), .i_run (i_run), .i_ex_mem (ex_mem),
    .bus (data_bus.requester),
    .o_fwd_result (fwd_result), .o_fwd_rd (fwd_rd), .o_fwd_we (fwd_we),
    .o_wb_we (wb_we), .o_wb_rd (o_wb_rd), .o_wb_data (o_wb_data)
  );

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
/*
 * decode_stage
 * Control decode, immediate build, register file with same-cycle
 * writeback bypass, load-use stall and the ID/EX register
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module decode_stage import rv_pkg::*; (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_run,
  input  wire [`RV_XLEN-1:0]  i_if_pc,
  input  instr_t              i_if_instr,
  input  wire                 i_if_valid,
  input  wire                 i_redirect,
  input  wire                 i_wb_we,
  input  wire [4:0]           i_wb_rd,
  input  wire [`RV_XLEN-1:0]  i_wb_data,
  output logic                o_stall,
  output id_ex_t              o_id_ex
);

  logic [`RV_XLEN-1:0] regs [1:31];
  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  id_ex_t              id_ex_d;

  assign rs1 = i_if_instr.r.rs1;
  assign rs2 = i_if_instr.r.rs2;

  // ==============================
  // Controls and immediates
  // ==============================
  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ADD;
    // I immediate by default
    imm = {{20{i_if_instr.r.funct7[6]}}, i_if_instr.r.funct7, i_if_instr.r.rs2};
    case (i_if_instr.r.opcode)
      OP_R: begin
        ctrl.rd_we = 1'b1;
        case (i_if_instr.r.funct3)
          3'b000:  ctrl.alu_op = i_if_instr.r.funct7[5] ? SUB : ADD;
          3'b111:  ctrl.alu_op = AND;
          3'b110:  ctrl.alu_op = OR;
          3'b100:  ctrl.alu_op = XOR;
          3'b010:  ctrl.alu_op = SLT;
          default: ctrl.alu_op = ADD;
        endcase
      end
      OP_I: begin
        ctrl.use_imm = 1'b1;
        ctrl.rd_we   = 1'b1;
      end
      OP_LOAD: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_rd  = 1'b1;
        ctrl.rd_we   = 1'b1;
      end
      OP_STORE: begin
        ctrl.use_imm = 1'b1;
        ctrl.mem_wr  = 1'b1;
        imm = {{20{i_if_instr.s.imm_hi[6]}}, i_if_instr.s.imm_hi, i_if_instr.s.imm_lo};
      end
      OP_BRANCH: begin
        // ALU forms pc + imm as the target
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.branch  = 1'b1;
        imm = {{20{i_if_instr.s.imm_hi[6]}}, i_if_instr.s.imm_lo[0],
               i_if_instr.s.imm_hi[5:0], i_if_instr.s.imm_lo[4:1], 1'b0};
      end
      OP_JAL: begin
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.rd_we   = 1'b1;
        imm = {{12{i_if_instr.r.funct7[6]}}, i_if_instr.r.rs1, i_if_instr.r.funct3,
               i_if_instr.r.rs2[0], i_if_instr.r.funct7[5:0], i_if_instr.r.rs2[4:1], 1'b0};
      end
      default: ;
    endcase
  end

  // ==============================
  // Register file
  // ==============================
  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_we && i_wb_rd != 5'd0) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // Load in EX feeding this instruction
  assign o_stall = i_if_valid & o_id_ex.valid & o_id_ex.ctrl.mem_rd &
                   (o_id_ex.rd != 5'd0) & ((o_id_ex.rd == rs1) | (o_id_ex.rd == rs2));

  always_comb begin
    id_ex_d.pc    = i_if_pc;
    id_ex_d.imm   = imm;
    id_ex_d.rs1   = rs1;
    id_ex_d.rs2   = rs2;
    id_ex_d.rd    = i_if_instr.r.rd;
    id_ex_d.instr = i_if_instr;
    // x0 reads zero, writeback bypassed in the same cycle
    id_ex_d.rs1_data = (rs1 == 5'd0) ? '0 :
                       (i_wb_we && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
    id_ex_d.rs2_data = (rs2 == 5'd0) ? '0 :
                       (i_wb_we && i_wb_rd == rs2) ? i_wb_data : regs[rs2];
    // Bubble on stall or flush
    id_ex_d.valid = i_if_valid & ~o_stall & ~i_redirect;
    id_ex_d.ctrl  = id_ex_d.valid ? ctrl : '0;
  end

  // ID/EX
  always_ff @(posedge i_clk) begin
    if (!i_reset || !i_run) begin
      o_id_ex.valid <= 1'b0;
      o_id_ex.ctrl  <= '0;
    end else begin
      o_id_ex <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
/*
 * execute_stage
 * Operand forwarding from MEM and WB, ALU, BEQ/BNE decision,
 * redirect to fetch and the EX/MEM register
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module execute_stage import rv_pkg::*; (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_run,
  input  id_ex_t              i_id_ex,
  input  wire [`RV_XLEN-1:0]  i_mem_fwd_result,
  input  wire [4:0]           i_mem_fwd_rd,
  input  wire                 i_mem_fwd_we,
  input  wire [`RV_XLEN-1:0]  i_wb_data,
  input  wire [4:0]           i_wb_rd,
  input  wire                 i_wb_we,
  output logic                o_redirect,
  output logic [`RV_XLEN-1:0] o_target,
  output ex_mem_t             o_ex_mem
);

  logic [`RV_XLEN-1:0] fwd_a;
  logic [`RV_XLEN-1:0] fwd_b;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;
  logic                taken;

  // ==============================
  // Forwarding, rs1 and rs2 apart
  // ==============================
  // MEM is younger, so it beats WB
  always_comb begin
    fwd_a = i_id_ex.rs1_data;
    if (i_mem_fwd_we && i_mem_fwd_rd != 5'd0 && i_mem_fwd_rd == i_id_ex.rs1) begin
      fwd_a = i_mem_fwd_result;
    end else if (i_wb_we && i_wb_rd != 5'd0 && i_wb_rd == i_id_ex.rs1) begin
      fwd_a = i_wb_data;
    end
    fwd_b = i_id_ex.rs2_data;
    if (i_mem_fwd_we && i_mem_fwd_rd != 5'd0 && i_mem_fwd_rd == i_id_ex.rs2) begin
      fwd_b = i_mem_fwd_result;
    end else if (i_wb_we && i_wb_rd != 5'd0 && i_wb_rd == i_id_ex.rs2) begin
      fwd_b = i_wb_data;
    end
  end

  assign op_a = i_id_ex.ctrl.use_pc  ? i_id_ex.pc  : fwd_a;
  assign op_b = i_id_ex.ctrl.use_imm ? i_id_ex.imm : fwd_b;

  // ALU
  always_comb begin
    case (i_id_ex.ctrl.alu_op)
      SUB:     alu_out = op_a - op_b;
      AND:     alu_out = op_a & op_b;
      OR:      alu_out = op_a | op_b;
      XOR:     alu_out = op_a ^ op_b;
      SLT:     alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_out = op_a + op_b;
    endcase
  end

  // BEQ on funct3 000, BNE on 001
  assign taken      = (fwd_a == fwd_b) ^ i_id_ex.instr.r.funct3[0];
  assign o_redirect = i_id_ex.valid & (i_id_ex.ctrl.jump | (i_id_ex.ctrl.branch & taken));
  assign o_target   = alu_out;

  // EX/MEM
  always_ff @(posedge i_clk) begin
    if (!i_reset || !i_run) begin
      o_ex_mem.valid <= 1'b0;
      o_ex_mem.ctrl  <= '0;
    end else begin
      o_ex_mem.result     <= alu_out;
      o_ex_mem.store_data <= fwd_b;
      o_ex_mem.rd         <= i_id_ex.rd;
      o_ex_mem.ctrl       <= i_id_ex.ctrl;
      o_ex_mem.valid      <= i_id_ex.valid;
      o_ex_mem.pc_plus4   <= i_id_ex.pc + `RV_XLEN'd4;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
/*
 * fetch_stage
 * Program counter, fetch requests on the shared bus and the
 * IF/ID register. Redirect from EX loads the branch target
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module fetch_stage import rv_pkg::*; (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_run,
  input  wire                 i_stall,
  input  wire                 i_redirect,
  input  wire [`RV_XLEN-1:0]  i_target,
  mem_bus_if.requester        bus,
  output logic [`RV_XLEN-1:0] o_if_pc,
  output instr_t              o_if_instr,
  output logic                o_if_valid
);

  logic [`RV_XLEN-1:0] pc;

  // Read-only requester
  assign bus.req   = i_run;
  assign bus.we    = 1'b0;
  assign bus.addr  = pc;
  assign bus.wdata = '0;

  // PC and IF/ID valid
  always_ff @(posedge i_clk) begin
    if (!i_reset || !i_run) begin
      pc         <= `RV_RESET_PC;
      o_if_valid <= 1'b0;
    end else if (i_redirect) begin
      // Redirect beats stall, younger fetch dropped
      pc         <= i_target;
      o_if_valid <= 1'b0;
    end else if (!i_stall) begin
      if (bus.gnt) begin
        pc <= pc + `RV_XLEN'd4;
      end
      // Lost grant leaves PC put and sends no word down
      o_if_valid <= bus.gnt;
    end
  end

  // IF/ID payload
  always_ff @(posedge i_clk) begin
    if (!i_stall && bus.gnt) begin
      o_if_pc    <= pc;
      o_if_instr <= bus.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_bus_if.sv ====
/*
 * mem_bus_if
 * Requester side of the unified memory bus. Req and gnt high in
 * one cycle is one access; reads return in the same cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

interface mem_bus_if;
  logic                req;
  logic                we;
  logic [`RV_XLEN-1:0] addr;
  logic [`RV_XLEN-1:0] wdata;
  logic [`RV_XLEN-1:0] rdata;
  logic                gnt;

  // Stage side
  modport requester (output req, we, addr, wdata, input rdata, gnt);
  // Memory side
  modport memory (input req, we, addr, wdata, output rdata, gnt);
endinterface

`default_nettype wire

// ==== rtl/memory_stage.sv ====
/*
 * memory_stage
 * Data access on the shared bus, result select, MEM/WB register
 * and the writeback port into the register file
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module memory_stage import rv_pkg::*; (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_run,
  input  ex_mem_t             i_ex_mem,
  mem_bus_if.requester        bus,
  output logic [`RV_XLEN-1:0] o_fwd_result,
  output logic [4:0]          o_fwd_rd,
  output logic                o_fwd_we,
  output logic                o_wb_we,
  output logic [4:0]          o_wb_rd,
  output logic [`RV_XLEN-1:0] o_wb_data
);

  mem_wb_t mem_wb;

  // Data beats fetch, access done this cycle
  assign bus.req   = i_ex_mem.valid & (i_ex_mem.ctrl.mem_rd | i_ex_mem.ctrl.mem_wr);
  assign bus.we    = i_ex_mem.ctrl.mem_wr;
  assign bus.addr  = i_ex_mem.result;
  assign bus.wdata = i_ex_mem.store_data;

  // Load data, link value or ALU result
  assign o_fwd_result = i_ex_mem.ctrl.mem_rd ? bus.rdata :
                        i_ex_mem.ctrl.jump   ? i_ex_mem.pc_plus4 : i_ex_mem.result;
  assign o_fwd_rd     = i_ex_mem.rd;
  assign o_fwd_we     = i_ex_mem.valid & i_ex_mem.ctrl.rd_we;

  // MEM/WB
  always_ff @(posedge i_clk) begin
    if (!i_reset || !i_run) begin
      mem_wb.valid <= 1'b0;
      mem_wb.rd_we <= 1'b0;
    end else begin
      mem_wb.valid  <= i_ex_mem.valid;
      mem_wb.rd_we  <= o_fwd_we & (i_ex_mem.rd != 5'd0);
      mem_wb.rd     <= i_ex_mem.rd;
      mem_wb.result <= o_fwd_result;
    end
  end

  assign o_wb_we   = mem_wb.valid & mem_wb.rd_we;
  assign o_wb_rd   = mem_wb.rd;
  assign o_wb_data = mem_wb.result;

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
/*
 * rv_pkg
 * Types shared by the pipeline stages: opcodes, ALU operations,
 * the two views of an instruction word and the stage records
 */
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

  // Major opcodes kept in the subset
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_I      = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT} alu_op_t;

  // R view, also serves I and J immediates
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_view_t;

  // S view, store and branch immediates sit in rd/funct7 slots
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r;
    s_view_t s;
  } instr_t;

  // Decoded controls
  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    use_pc;
    logic    mem_rd;
    logic    mem_wr;
    logic    branch;
    logic    jump;
    logic    rd_we;
  } ctrl_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    instr_t              instr;
    ctrl_t               ctrl;
    logic                valid;
  } id_ex_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] store_data;
    logic [4:0]          rd;
    ctrl_t               ctrl;
    logic                valid;
    logic [`RV_XLEN-1:0] pc_plus4;
  } ex_mem_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] result;
    logic [4:0]          rd;
    logic                rd_we;
    logic                valid;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/shared_memory.sv ====
/*
 * shared_memory
 * Unified word memory behind a fixed-priority arbiter.
 * Program load port first, then data access, then fetch.
 * One read port returns the granted word combinationally
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module shared_memory (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire                 i_load_we,
  input  wire [`RV_XLEN-1:0]  i_load_addr,
  input  wire [`RV_XLEN-1:0]  i_load_data,
  input  wire                 i_run,
  mem_bus_if.memory           fetch,
  mem_bus_if.memory           data
);

  logic [`RV_XLEN-1:0] mem [0:`RV_MEM_WORDS-1];
  logic                load_gnt;
  logic [`RV_MEM_AW-1:0] rd_word;

  // Arbitration
  // Load port only while the core is halted
  assign load_gnt   = i_load_we & ~i_run;
  assign data.gnt   = data.req & ~load_gnt;
  assign fetch.gnt  = fetch.req & ~load_gnt & ~data.req;

  // Single read port, data address wins
  assign rd_word     = data.req ? data.addr[`RV_MEM_AW+1:2] : fetch.addr[`RV_MEM_AW+1:2];
  assign data.rdata  = mem[rd_word];
  assign fetch.rdata = mem[rd_word];

  // Writes commit at the edge, none while reset is held
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      if (load_gnt) begin
        mem[i_load_addr[`RV_MEM_AW+1:2]] <= i_load_data;
      end else if (data.gnt && data.we) begin
        mem[data.addr[`RV_MEM_AW+1:2]] <= data.wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it, then look for the pass message

rm -rf obj_dir sim.log build.log

verilator --binary -Wno-fatal -f verilog.f --top-module tb_core -o sim_core \
  > build.log 2>&1 \
  && ./obj_dir/sim_core > sim.log 2>&1 \
  || echo "build or simulation returned an error, see build.log and sim.log"

cat sim.log 2>/dev/null

grep -q "^test passed$" sim.log 2>/dev/null && exit 0 || exit 1

// ==== testbench/core_checker.sv ====
/*
 * core_checker
 * Watches the core's retirement port and compares each write with
 * the queue of writes produced by the ISA model. Keeps per-test
 * and total counts
 */
`timescale 1ns/1ps
`default_nettype none

module core_checker (
  input wire        i_clk,
  input wire        i_reset,
  input wire        i_wb_valid,
  input wire [4:0]  i_wb_rd,
  input wire [31:0] i_wb_data
);

  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [4:0]  want_rd;
  logic [31:0] want_data;
  string       test_name = "none";
  int          test_checks = 0;
  int          test_errors = 0;
  int          total_checks = 0;
  int          total_errors = 0;
  int          pending = 0;

  // Model side
  task push_expect(input logic [4:0] rd, input logic [31:0] data);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    pending = exp_rd.size();
  endtask

  task start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  // Leftover writes mean the core stopped early
  task end_test();
    if (exp_rd.size() != 0) begin
      $display("%s: %0d expected writes never retired", test_name, exp_rd.size());
      test_errors++;
      exp_rd.delete();
      exp_data.delete();
      pending = 0;
    end
    $display("%s: %0d writes checked, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  // ==============================
  // Retirement compare
  // ==============================
  always @(posedge i_clk) begin
    if (i_reset && i_wb_valid) begin
      if (exp_rd.size() == 0) begin
        $display("%s: write to x%0d retired when the model had no write left",
                 test_name, i_wb_rd);
        test_errors++;
      end else begin
        want_rd   = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        test_checks++;
        if (want_rd !== i_wb_rd || want_data !== i_wb_data) begin
          $display("FAILED %s: expected x%0d=%08h, actual x%0d=%08h",
                   test_name, want_rd, want_data, i_wb_rd, i_wb_data);
          test_errors++;
        end
      end
      pending = exp_rd.size();
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_core.sv ====
/*
 * tb_core
 * Random program testbench for the pipelined core. Builds five
 * programs, runs each through an ISA model, loads them over the
 * load port and lets the checker compare retired writes
 */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module tb_core;

  localparam int N = 150;
  localparam int PAD = 4;
  localparam int DATA_LO = `RV_DATA_BASE / 4;
  localparam int DATA_WORDS = 256;
  localparam int LOAD_CYCLES = N + PAD + DATA_WORDS + 60;
  localparam int TIMEOUT_NS = 5 * N * 8 * 4 + 5 * LOAD_CYCLES * 4 + 4000;

  // Instruction kinds
  localparam int K_R    = 0;
  localparam int K_ADDI = 1;
  localparam int K_LW   = 2;
  localparam int K_SW   = 3;
  localparam int K_BR   = 4;
  localparam int K_JAL  = 5;

  logic        clk = 1'b0;
  logic        reset;
  logic        run;
  logic        load_we;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  wire         wb_valid;
  wire  [4:0]  wb_rd;
  wire  [31:0] wb_data;

  int          p_kind [N];
  int          p_f [N];
  int          p_rd [N];
  int          p_rs1 [N];
  int          p_rs2 [N];
  int          p_imm [N];
  logic [31:0] mregs [32];
  logic [31:0] mdata [0:`RV_MEM_WORDS-1];
  string       names [5] = '{"alu_only", "back_to_back", "load_use", "control_flow",
                             "mixed_stress"};

  always #2 clk = ~clk;

  core_top dut (
    .i_clk (clk), .i_reset (reset), .i_run (run),
    .i_load_we (load_we), .i_load_addr (load_addr), .i_load_data (load_data),
    .o_wb_valid (wb_valid), .o_wb_rd (wb_rd), .o_wb_data (wb_data)
  );

  core_checker chk (
    .i_clk (clk), .i_reset (reset), .i_wb_valid (wb_valid),
    .i_wb_rd (wb_rd), .i_wb_data (wb_data)
  );

  // ==============================
  // Program generation
  // ==============================
  function automatic int rand_imm();
    return int'($urandom_range(0, 4095)) - 2048;
  endfunction

  // Word aligned address inside the data region
  function automatic int rand_addr();
    return `RV_DATA_BASE + 4 * int'($urandom_range(0, DATA_WORDS - 1));
  endfunction

  // Forward offset that stays inside the program
  function automatic int fwd_offset(input int idx);
    int room;
    room = N - 1 - idx;
    return 4 * int'($urandom_range(1, (room < 6) ? room : 6));
  endfunction

  task automatic set_instr(input int idx, input int kind, input int f, input int rd,
                           input int rs1, input int rs2, input int imm);
    p_kind[idx] = kind;
    p_f[idx]    = f;
    p_rd[idx]   = rd;
    p_rs1[idx]  = rs1;
    p_rs2[idx]  = rs2;
    p_imm[idx]  = imm;
  endtask

  task automatic gen_program(input int test);
    int i;
    int r;
    int sel;
    int prev;
    i = 0;
    prev = 1;
    // Default everywhere is the JAL x0, 0 self-loop
    for (int k = 0; k < N; k++) begin
      set_instr(k, K_JAL, 0, 0, 0, 0, 0);
    end
    while (i < N - 1) begin
      sel = int'($urandom_range(0, 9));
      if (test == 0) begin
        if (sel < 6) set_instr(i, K_R, int'($urandom_range(0, 5)), int'($urandom_range(0, 7)),
                               int'($urandom_range(0, 7)), int'($urandom_range(0, 7)), 0);
        else set_instr(i, K_ADDI, 0, int'($urandom_range(0, 7)), int'($urandom_range(0, 7)),
                       0, rand_imm());
        i++;
      end else if (test == 1) begin
        // Each one reads the previous rd on one or both sides
        r = int'($urandom_range(1, 7));
        if (sel < 6) set_instr(i, K_R, int'($urandom_range(0, 5)), r, prev,
                               (sel < 3) ? prev : int'($urandom_range(0, 7)), 0);
        else set_instr(i, K_ADDI, 0, r, prev, 0, rand_imm());
        prev = r;
        i++;
      end else if (test == 2 && i + 4 <= N - 1) begin
        // ADDI, SW, LW, then a consumer of the loaded value
        r = rand_addr();
        prev = int'($urandom_range(1, 7));
        set_instr(i, K_ADDI, 0, prev, int'($urandom_range(0, 7)), 0, rand_imm());
        set_instr(i + 1, K_SW, 0, 0, 0, prev, r);
        prev = int'($urandom_range(1, 7));
        set_instr(i + 2, K_LW, 0, prev, 0, 0, r);
        set_instr(i + 3, K_R, int'($urandom_range(0, 5)), int'($urandom_range(1, 7)),
                  (sel < 5) ? prev : int'($urandom_range(0, 7)), prev, 0);
        i += 4;
      end else if (test == 3) begin
        if (sel < 4) set_instr(i, K_ADDI, 0, int'($urandom_range(1, 3)),
                               int'($urandom_range(0, 3)), 0, int'($urandom_range(0, 2)));
        else if (sel < 8) set_instr(i, K_BR, sel & 1, 0, int'($urandom_range(0, 3)),
                                    int'($urandom_range(0, 3)), fwd_offset(i));
        else set_instr(i, K_JAL, 0, int'($urandom_range(0, 7)), 0, 0, fwd_offset(i));
        i++;
      end else begin
        // All kinds with about 40 percent memory traffic
        r = int'($urandom_range(0, 7));
        case (sel)
          0, 1, 2: set_instr(i, K_R, int'($urandom_range(0, 5)), r,
                             int'($urandom_range(0, 7)), int'($urandom_range(0, 7)), 0);
          3:       set_instr(i, K_ADDI, 0, r, int'($urandom_range(0, 7)), 0, rand_imm());
          4, 5:    set_instr(i, K_LW, 0, r, 0, 0, rand_addr());
          6, 7:    set_instr(i, K_SW, 0, 0, 0, r, rand_addr());
          8:       set_instr(i, K_BR, r & 1, 0, int'($urandom_range(0, 7)),
                             int'($urandom_range(0, 7)), fwd_offset(i));
          default: set_instr(i, K_JAL, 0, r, 0, 0, fwd_offset(i));
        endcase
        i++;
      end
    end
  endtask

  // ==============================
  // Encoding and ISA model
  // ==============================
  function automatic logic [31:0] encode(input int idx);
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    imm = p_imm[idx];
    rd  = p_rd[idx][4:0];
    rs1 = p_rs1[idx][4:0];
    rs2 = p_rs2[idx][4:0];
    case (p_f[idx])
      2:       f3 = 3'b111;
      3:       f3 = 3'b110;
      4:       f3 = 3'b100;
      5:       f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    case (p_kind[idx])
      K_R:    return {(p_f[idx] == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
      K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'h13};
      K_LW:   return {imm[11:0], 5'd0, 3'b010, rd, 7'h03};
      K_SW:   return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
      K_BR:   return {imm[12], imm[10:5], rs2, rs1, 2'b00, p_f[idx][0], imm[4:1], imm[11],
                      7'h63};
      default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endcase
  endfunction

  // Data fill depends on every address bit and the test
  function automatic logic [31:0] fill_word(input int word, input int test);
    return (word * 32'h9e37_79b1) ^ (test << 24) ^ word;
  endfunction

  task automatic model_write(input int rd, input logic [31:0] value);
    if (rd != 0) begin
      mregs[rd] = value;
      chk.push_expect(rd[4:0], value);
    end
  endtask

  task automatic run_model();
    int          idx;
    int          next;
    int          steps;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    idx = 0;
    steps = 0;
    while (idx != N - 1 && steps < 4 * N) begin
      a = mregs[p_rs1[idx]];
      b = mregs[p_rs2[idx]];
      next = idx + 1;
      case (p_kind[idx])
        K_R: begin
          case (p_f[idx])
            1:       v = a - b;
            2:       v = a & b;
            3:       v = a | b;
            4:       v = a ^ b;
            5:       v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: v = a + b;
          endcase
          model_write(p_rd[idx], v);
        end
        K_ADDI: model_write(p_rd[idx], a + p_imm[idx]);
        K_LW:   model_write(p_rd[idx], mdata[p_imm[idx] / 4]);
        K_SW:   mdata[p_imm[idx] / 4] = b;
        // BEQ on f 0, BNE on f 1
        K_BR:   if ((a == b) != (p_f[idx] == 1)) next = idx + p_imm[idx] / 4;
        default: begin
          model_write(p_rd[idx], 4 * idx + 4);
          next = idx + p_imm[idx] / 4;
        end
      endcase
      idx = next;
      steps++;
    end
  endtask

  task automatic load_word(input int word, input logic [31:0] value);
    @(posedge clk);
    load_we   <= 1'b1;
    load_addr <= 32'(4 * word);
    load_data <= value;
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    reset     = 1'b0;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(32'h0ba8577c));
    for (int k = 0; k < 32; k++) begin
      mregs[k] = '0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b1;
    for (int t = 0; t < 5; t++) begin
      gen_program(t);
      for (int w = DATA_LO; w < DATA_LO + DATA_WORDS; w++) begin
        mdata[w] = fill_word(w, t);
      end
      chk.start_test(names[t]);
      run_model();
      for (int w = 0; w < N; w++) begin
        load_word(w, encode(w));
      end
      // Wrong-path fetches past the end see self-loops
      for (int w = N; w < N + PAD; w++) begin
        load_word(w, 32'h0000_006f);
      end
      for (int w = DATA_LO; w < DATA_LO + DATA_WORDS; w++) begin
        load_word(w, fill_word(w, t));
      end
      @(posedge clk);
      load_we <= 1'b0;
      run     <= 1'b1;
      @(posedge clk);
      // Queue count settles between rising edges
      while (chk.pending != 0) @(negedge clk);
      // Room for stray writes to show up
      repeat (40) @(posedge clk);
      run <= 1'b0;
      repeat (2) @(posedge clk);
      chk.end_test();
    end
    $display("tests: 5, writes checked: %0d, errors: %0d", chk.total_checks,
             chk.total_errors);
    if (chk.total_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the core stopped retiring before all tests finished");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
rtl/rv_pkg.sv
rtl/mem_bus_if.sv
rtl/shared_memory.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core_top.sv
testbench/core_checker.sv
testbench/tb_core.sv
